/* source/mc_link_pkg.sv */
`default_nettype none

package mc_link_pkg;

  localparam int link_width_gp = 64;
  localparam int cord_width_gp = 4;

  typedef enum logic {
    e_kind_req = 1'b0
    , e_kind_rsp = 1'b1
  } mc_kind_e;

  // Request as issued by a core or the host
  typedef struct packed {
    mc_kind_e                 kind;
    logic [2:0]               opcode;
    logic [cord_width_gp-1:0] src_x;
    logic [cord_width_gp-1:0] src_y;
    logic [19:0]              addr;
    logic [31:0]              data;
  } mc_req_packet_s;

  typedef struct packed {
    mc_kind_e                 kind;
    logic [2:0]               opcode;
    logic [cord_width_gp-1:0] dst_x;
    logic [cord_width_gp-1:0] dst_y;
    logic [19:0]              pad;
    logic [31:0]              data;
  } mc_rsp_packet_s;

  // Kind bit is the MSB in both views
  typedef union packed {
    mc_req_packet_s req;
    mc_rsp_packet_s rsp;
  } mc_link_packet_u;

endpackage

`default_nettype wire

/* source/host_reg_pkg.sv */
`default_nettype none

package host_reg_pkg;

  localparam int dev_addr_width_gp = 20;
  localparam int dword_width_gp    = 64;
  localparam int reg_els_gp        = 9;

  typedef enum logic [3:0] {
    e_bp_req_fifo          = 4'd0
    , e_bp_req_credits     = 4'd1
    , e_mc_rsp_fifo        = 4'd2
    , e_mc_rsp_entries     = 4'd3
    , e_mc_req_fifo        = 4'd4
    , e_mc_req_entries     = 4'd5
    , e_bp_rsp_fifo        = 4'd6
    , e_bp_rsp_credits     = 4'd7
    , e_endpoint_credits   = 4'd8
  } host_reg_e;

  // Index 0 is the rightmost entry
  localparam logic [reg_els_gp-1:0][dev_addr_width_gp-1:0] reg_base_addr_gp = {
    20'h0_9000, 20'h0_8000, 20'h0_7000, 20'h0_6000, 20'h0_5000
    , 20'h0_4000, 20'h0_3000, 20'h0_2000, 20'h0_1000
  };

endpackage

`default_nettype wire

/* source/link_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module link_fifo
  #(parameter int width_p = 64
    , parameter int els_p = 4
    , localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
    )
  (input wire                  clk_i
   , input wire                reset_i

   , input wire [width_p-1:0]  data_i
   , input wire                v_i
   , output logic              ready_and_o

   , output logic [width_p-1:0] data_o
   , output logic               v_o
   , input wire                 yumi_i
   );

  logic [els_p-1:0][width_p-1:0] mem_r;
  logic [ptr_width_lp-1:0]       rptr_r, wptr_r, rptr_n, wptr_n;
  logic                          full_r, full_n;
  logic                          ready_r;
  logic                          push, pop;

  // Push and pop together are allowed when full
  assign ready_and_o = ready_r | yumi_i;
  assign push = v_i & ready_and_o;
  assign pop  = yumi_i;

  assign rptr_n = pop
    ? ((rptr_r == ptr_width_lp'(els_p-1)) ? '0 : rptr_r + ptr_width_lp'(1)) : rptr_r;
  assign wptr_n = push
    ? ((wptr_r == ptr_width_lp'(els_p-1)) ? '0 : wptr_r + ptr_width_lp'(1)) : wptr_r;

  always_comb begin
    full_n = full_r;
    if (push && !pop) begin
      full_n = (wptr_n == rptr_r);
    end else if (pop && !push) begin
      full_n = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rptr_r  <= '0;
      wptr_r  <= '0;
      full_r  <= 1'b0;
      ready_r <= 1'b0; // Held low until out of reset
    end else begin
      rptr_r  <= rptr_n;
      wptr_r  <= wptr_n;
      full_r  <= full_n;
      ready_r <= ~full_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  assign v_o    = full_r | (rptr_r != wptr_r);
  assign data_o = mem_r[rptr_r];

endmodule

`default_nettype wire

/* source/host_register_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module host_register_decode
  import host_reg_pkg::*;
  (input wire                                             clk_i
   , input wire                                           reset_i

   , input wire                                           mem_fwd_v_i
   , input wire                                           mem_fwd_we_i
   , input wire [dev_addr_width_gp-1:0]                   mem_fwd_addr_i
   , input wire [dword_width_gp-1:0]                      mem_fwd_data_i
   , output logic                                         mem_fwd_ready_and_o

   , output logic                                         mem_rev_v_o
   , output logic [dword_width_gp-1:0]                    mem_rev_data_o
   , input wire                                           mem_rev_ready_and_i

   , output logic [reg_els_gp-1:0]                        r_v_o
   , output logic [reg_els_gp-1:0]                        w_v_o
   , output logic [dword_width_gp-1:0]                    data_o
   , input wire [reg_els_gp-1:0][dword_width_gp-1:0]      data_i
   );

  logic                      accept;
  logic [reg_els_gp-1:0]     hit;
  logic [dword_width_gp-1:0] rd_sel;
  logic                      rev_v_r;
  logic [dword_width_gp-1:0] rev_data_r;

  // One command in flight at a time
  assign mem_fwd_ready_and_o = ~rev_v_r;
  assign accept = mem_fwd_v_i & mem_fwd_ready_and_o;

  always_comb begin
    for (int i = 0; i < reg_els_gp; i++) begin
      hit[i] = (mem_fwd_addr_i == reg_base_addr_gp[i]);
    end
  end

  assign r_v_o  = {reg_els_gp{accept & ~mem_fwd_we_i}} & hit;
  assign w_v_o  = {reg_els_gp{accept &  mem_fwd_we_i}} & hit;
  assign data_o = mem_fwd_data_i;

  // Unmapped offsets fall through as zero
  always_comb begin
    rd_sel = '0;
    for (int i = 0; i < reg_els_gp; i++) begin
      if (hit[i]) begin
        rd_sel = data_i[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rev_v_r <= 1'b0;
    end else if (accept) begin
      rev_v_r <= 1'b1;
    end else if (mem_rev_ready_and_i) begin
      rev_v_r <= 1'b0; // Response taken
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rev_data_r <= mem_fwd_we_i ? '0 : rd_sel; // Writes answer with zero
    end
  end

  assign mem_rev_v_o    = rev_v_r;
  assign mem_rev_data_o = rev_data_r;

endmodule

`default_nettype wire

/* source/endpoint_to_fifos.sv */
`timescale 1ns/1ps
`default_nettype none

module endpoint_to_fifos
  import mc_link_pkg::*;
  #(parameter int ep_fifo_els_p = 4
    , parameter int max_credits_p = 3
    , localparam int credit_width_lp = $clog2(max_credits_p+1)
    )
  (input wire                          clk_i
   , input wire                        reset_i

   , input wire [link_width_gp-1:0]    host_req_i
   , input wire                        host_req_v_i
   , output logic                      host_req_ready_o

   , input wire [link_width_gp-1:0]    host_rsp_i
   , input wire                        host_rsp_v_i
   , output logic                      host_rsp_ready_o

   , output logic [link_width_gp-1:0]  mc_req_o
   , output logic                      mc_req_v_o
   , input wire                        mc_req_yumi_i

   , output logic [link_width_gp-1:0]  mc_rsp_o
   , output logic                      mc_rsp_v_o
   , input wire                        mc_rsp_yumi_i

   , input wire                        link_v_i
   , input wire [link_width_gp-1:0]    link_data_i
   , output logic                      link_ready_o

   , output logic                      link_v_o
   , output logic [link_width_gp-1:0]  link_data_o
   , input wire                        link_ready_i

   , input wire [cord_width_gp-1:0]    global_x_i
   , input wire [cord_width_gp-1:0]    global_y_i

   , output logic [credit_width_lp-1:0] credits_used_o
   );

  mc_link_packet_u            out_req_pkt, stamped_req, in_pkt;
  logic [link_width_gp-1:0]   out_rsp_data;
  logic                       out_req_v, out_rsp_v, out_req_yumi, out_rsp_yumi;
  logic                       sel_rsp, send_req, credits_ok, req_lock_r;
  logic                       in_is_rsp, in_req_ready, in_rsp_ready;
  logic                       credit_inc, credit_dec;
  logic [credit_width_lp-1:0] credits_r;

  link_fifo #(.width_p(link_width_gp), .els_p(ep_fifo_els_p)) out_req_fifo
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.data_i(host_req_i), .v_i(host_req_v_i), .ready_and_o(host_req_ready_o)
     ,.data_o(out_req_pkt), .v_o(out_req_v), .yumi_i(out_req_yumi)
     );

  link_fifo #(.width_p(link_width_gp), .els_p(ep_fifo_els_p)) out_rsp_fifo
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.data_i(host_rsp_i), .v_i(host_rsp_v_i), .ready_and_o(host_rsp_ready_o)
     ,.data_o(out_rsp_data), .v_o(out_rsp_v), .yumi_i(out_rsp_yumi)
     );

  // Local coordinates go into every outbound request
  always_comb begin
    stamped_req = out_req_pkt;
    stamped_req.req.src_x = global_x_i;
    stamped_req.req.src_y = global_y_i;
  end

  // Responses first, unless a stalled request already owns the link
  assign credits_ok = (credits_r < credit_width_lp'(max_credits_p));
  assign sel_rsp    = out_rsp_v & ~req_lock_r;
  assign send_req   = ~sel_rsp & out_req_v & credits_ok;

  assign link_v_o     = sel_rsp | send_req;
  assign out_rsp_yumi = sel_rsp & link_ready_i;
  assign out_req_yumi = send_req & link_ready_i;

  always_comb begin
    if (sel_rsp) begin
      link_data_o = out_rsp_data; // Verbatim
    end else begin
      link_data_o = stamped_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_lock_r <= 1'b0;
    end else begin
      req_lock_r <= send_req & ~link_ready_i;
    end
  end

  // Inbound steering by kind
  assign in_pkt       = link_data_i;
  assign in_is_rsp    = (in_pkt.rsp.kind == e_kind_rsp);
  assign link_ready_o = in_is_rsp ? in_rsp_ready : in_req_ready;

  link_fifo #(.width_p(link_width_gp), .els_p(ep_fifo_els_p)) in_req_fifo
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.data_i(link_data_i), .v_i(link_v_i & ~in_is_rsp), .ready_and_o(in_req_ready)
     ,.data_o(mc_req_o), .v_o(mc_req_v_o), .yumi_i(mc_req_yumi_i)
     );

  link_fifo #(.width_p(link_width_gp), .els_p(ep_fifo_els_p)) in_rsp_fifo
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.data_i(link_data_i), .v_i(link_v_i & in_is_rsp), .ready_and_o(in_rsp_ready)
     ,.data_o(mc_rsp_o), .v_o(mc_rsp_v_o), .yumi_i(mc_rsp_yumi_i)
     );

  assign credit_inc = out_req_yumi;
  assign credit_dec = link_v_i & in_is_rsp & in_rsp_ready & (credits_r != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_r <= '0;
    end else begin
      credits_r <= credits_r + credit_width_lp'(credit_inc) - credit_width_lp'(credit_dec);
    end
  end

  assign credits_used_o = credits_r;

endmodule

`default_nettype wire

/* source/manycore_fifo_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module manycore_fifo_bridge
  import mc_link_pkg::*;
  import host_reg_pkg::*;
  #(parameter int ep_fifo_els_p = 4
    , parameter int max_credits_p = 3
    )
  (input wire                           clk_i
   , input wire                         reset_i

   , input wire                         mem_fwd_v_i
   , input wire                         mem_fwd_we_i
   , input wire [dev_addr_width_gp-1:0] mem_fwd_addr_i
   , input wire [dword_width_gp-1:0]    mem_fwd_data_i
   , output logic                       mem_fwd_ready_and_o

   , output logic                       mem_rev_v_o
   , output logic [dword_width_gp-1:0]  mem_rev_data_o
   , input wire                         mem_rev_ready_and_i

   , input wire                         link_v_i
   , input wire [link_width_gp-1:0]     link_data_i
   , output logic                       link_ready_o

   , output logic                       link_v_o
   , output logic [link_width_gp-1:0]   link_data_o
   , input wire                         link_ready_i

   , input wire [cord_width_gp-1:0]     global_x_i
   , input wire [cord_width_gp-1:0]     global_y_i
   );

  localparam int credit_width_lp = $clog2(max_credits_p+1);

  logic [reg_els_gp-1:0]                     r_v_lo, w_v_lo;
  logic [dword_width_gp-1:0]                 data_lo;
  logic [reg_els_gp-1:0][dword_width_gp-1:0] data_li;
  logic                                      mc_req_pop_r, mc_rsp_pop_r;
  logic [link_width_gp-1:0]                  mc_req_lo, mc_rsp_lo;
  logic                                      mc_req_v_lo, mc_rsp_v_lo;
  logic                                      host_req_ready_lo, host_rsp_ready_lo;
  logic [credit_width_lp-1:0]                credits_used_lo;

  host_register_decode i_decode
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.mem_fwd_v_i(mem_fwd_v_i), .mem_fwd_we_i(mem_fwd_we_i)
     ,.mem_fwd_addr_i(mem_fwd_addr_i), .mem_fwd_data_i(mem_fwd_data_i)
     ,.mem_fwd_ready_and_o(mem_fwd_ready_and_o)
     ,.mem_rev_v_o(mem_rev_v_o), .mem_rev_data_o(mem_rev_data_o)
     ,.mem_rev_ready_and_i(mem_rev_ready_and_i)
     ,.r_v_o(r_v_lo), .w_v_o(w_v_lo), .data_o(data_lo), .data_i(data_li)
     );

  // Pop one cycle after the read samples the head
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mc_req_pop_r <= 1'b0;
      mc_rsp_pop_r <= 1'b0;
    end else begin
      mc_req_pop_r <= r_v_lo[e_mc_req_fifo];
      mc_rsp_pop_r <= r_v_lo[e_mc_rsp_fifo];
    end
  end

  endpoint_to_fifos
    #(.ep_fifo_els_p(ep_fifo_els_p), .max_credits_p(max_credits_p))
    i_endpoint
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.host_req_i(data_lo), .host_req_v_i(w_v_lo[e_bp_req_fifo])
     ,.host_req_ready_o(host_req_ready_lo)
     ,.host_rsp_i(data_lo), .host_rsp_v_i(w_v_lo[e_bp_rsp_fifo])
     ,.host_rsp_ready_o(host_rsp_ready_lo)
     ,.mc_req_o(mc_req_lo), .mc_req_v_o(mc_req_v_lo)
     ,.mc_req_yumi_i(mc_req_pop_r & mc_req_v_lo) // Empty reads pop nothing
     ,.mc_rsp_o(mc_rsp_lo), .mc_rsp_v_o(mc_rsp_v_lo)
     ,.mc_rsp_yumi_i(mc_rsp_pop_r & mc_rsp_v_lo)
     ,.link_v_i(link_v_i), .link_data_i(link_data_i), .link_ready_o(link_ready_o)
     ,.link_v_o(link_v_o), .link_data_o(link_data_o), .link_ready_i(link_ready_i)
     ,.global_x_i(global_x_i), .global_y_i(global_y_i)
     ,.credits_used_o(credits_used_lo)
     );

  assign data_li[e_bp_req_fifo]      = '0; // Write only
  assign data_li[e_bp_req_credits]   = dword_width_gp'(host_req_ready_lo);
  assign data_li[e_mc_rsp_fifo]      = mc_rsp_lo;
  assign data_li[e_mc_rsp_entries]   = dword_width_gp'(mc_rsp_v_lo);
  assign data_li[e_mc_req_fifo]      = mc_req_lo;
  assign data_li[e_mc_req_entries]   = dword_width_gp'(mc_req_v_lo);
  assign data_li[e_bp_rsp_fifo]      = '0; // Write only
  assign data_li[e_bp_rsp_credits]   = dword_width_gp'(host_rsp_ready_lo);
  assign data_li[e_endpoint_credits] = dword_width_gp'(credits_used_lo);

endmodule

`default_nettype wire

/* tb/manycore_fifo_bridge_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module manycore_fifo_bridge_properties
  #(parameter int max_credits_p = 3
    , localparam int credit_width_lp = $clog2(max_credits_p+1)
    )
  (input wire                          clk_i
   , input wire                        reset_i
   , input wire                        fwd_v_i
   , input wire                        fwd_ready_i
   , input wire                        rev_v_i
   , input wire [63:0]                 rev_data_i
   , input wire                        rev_ready_i
   , input wire                        out_v_i
   , input wire [63:0]                 out_data_i
   , input wire                        out_ready_i
   , input wire                        in_ready_i
   , input wire [credit_width_lp-1:0]  credits_i
   );

  // Cycle after a reset cycle
  reset_state_a: assert property (@(posedge clk_i)
    reset_i |=> (!out_v_i && !in_ready_i && !rev_v_i && credits_i == '0))
    else $error("outputs not idle after reset");

  link_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    out_v_i && !out_ready_i |=> out_v_i && $stable(out_data_i))
    else $error("link output dropped or changed under back-pressure");

  rev_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    rev_v_i && !rev_ready_i |=> rev_v_i && $stable(rev_data_i))
    else $error("host response dropped or changed under back-pressure");

  credit_limit_a: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_i <= credit_width_lp'(max_credits_p))
    else $error("outstanding credits above limit");

  rsp_timing_a: assert property (@(posedge clk_i) disable iff (reset_i)
    fwd_v_i && fwd_ready_i |=> rev_v_i)
    else $error("host response not one cycle after acceptance");

endmodule

`default_nettype wire

/* tb/manycore_fifo_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module manycore_fifo_bridge_tb
  import host_reg_pkg::*;
  ();

  // About 80 host commands and 40 link packets at up to ~10 cycles each under stalls
  localparam int max_cycles_lp = 4000;
  localparam logic [3:0] gx_lp = 4'h5;
  localparam logic [3:0] gy_lp = 4'h9;

  logic clk_i = 1'b0, reset_i;
  logic mem_fwd_v_i, mem_fwd_we_i, mem_fwd_ready_and_o;
  logic [19:0] mem_fwd_addr_i;
  logic [63:0] mem_fwd_data_i, mem_rev_data_o, link_data_i, link_data_o;
  logic mem_rev_v_o, mem_rev_ready_and_i;
  logic link_v_i, link_ready_o, link_v_o, link_ready_i;
  logic link_hold, rand_en;
  logic [31:0] rnd_ready, rnd_stim;
  logic [63:0] exp_out_req_q[$], exp_out_rsp_q[$], exp_in_rsp_q[$], exp_in_req_q[$];
  int cycles = 0, value_errs = 0, other_errs = 0, sent_req = 0, sent_rsp = 0;

  manycore_fifo_bridge #(.ep_fifo_els_p(4), .max_credits_p(3)) i_dut
    (.clk_i, .reset_i, .mem_fwd_v_i, .mem_fwd_we_i, .mem_fwd_addr_i, .mem_fwd_data_i
     ,.mem_fwd_ready_and_o, .mem_rev_v_o, .mem_rev_data_o, .mem_rev_ready_and_i
     ,.link_v_i, .link_data_i, .link_ready_o, .link_v_o, .link_data_o, .link_ready_i
     ,.global_x_i(gx_lp), .global_y_i(gy_lp));

  bind manycore_fifo_bridge manycore_fifo_bridge_properties
    #(.max_credits_p(max_credits_p)) i_props
    (.clk_i(clk_i), .reset_i(reset_i), .fwd_v_i(mem_fwd_v_i)
     ,.fwd_ready_i(mem_fwd_ready_and_o), .rev_v_i(mem_rev_v_o)
     ,.rev_data_i(mem_rev_data_o), .rev_ready_i(mem_rev_ready_and_i)
     ,.out_v_i(link_v_o), .out_data_i(link_data_o), .out_ready_i(link_ready_i)
     ,.in_ready_i(link_ready_o), .credits_i(credits_used_lo));

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Source fields replaced by local coordinates
  function automatic logic [63:0] stamp(input logic [63:0] p);
    return {p[63:60], gx_lp, gy_lp, p[51:0]};
  endfunction

  // Link-side responder ready and host response stalls
  always @(posedge clk_i) begin
    rnd_ready <= xorshift(rnd_ready);
    link_ready_i <= link_hold ? 1'b0 : (rand_en ? rnd_ready[0] : 1'b1);
    mem_rev_ready_and_i <= rand_en ? rnd_ready[7] : 1'b1;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles_lp) begin
      $display("Timeout: run did not finish within %0d cycles", max_cycles_lp);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Outbound link monitor, compared with the kind's own queue
  always @(negedge clk_i) begin
    if (!reset_i && link_v_o && link_ready_i) begin
      if (link_data_o[63] ? exp_out_rsp_q.size() == 0 : exp_out_req_q.size() == 0) begin
        other_errs++;
        $display("Unexpected packet on link output: %h", link_data_o);
      end else if (link_data_o[63]) begin
        compare("link_data_o", link_data_o, exp_out_rsp_q.pop_front());
        sent_rsp++;
      end else begin
        compare("link_data_o", link_data_o, stamp(exp_out_req_q.pop_front()));
        sent_req++;
      end
    end
  end

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic host_cmd(input logic we, input host_reg_e r, input logic [63:0] d,
                          output logic [63:0] rd);
    @(posedge clk_i);
    mem_fwd_v_i <= 1'b1;
    mem_fwd_we_i <= we;
    mem_fwd_addr_i <= reg_base_addr_gp[r];
    mem_fwd_data_i <= d;
    @(negedge clk_i);
    while (!mem_fwd_ready_and_o) @(negedge clk_i);
    @(posedge clk_i);
    mem_fwd_v_i <= 1'b0;
    @(negedge clk_i);
    while (!(mem_rev_v_o && mem_rev_ready_and_i)) @(negedge clk_i);
    rd = mem_rev_data_o;
  endtask

  task automatic host_write(input host_reg_e r, input logic [63:0] d);
    logic [63:0] rd;
    host_cmd(1'b1, r, d, rd);
    compare("mem_rev_data_o", rd, 64'h0);
  endtask

  task automatic host_read(input host_reg_e r, input logic [63:0] exp);
    logic [63:0] rd;
    host_cmd(1'b0, r, 64'h0, rd);
    compare($sformatf("mem_rev_data_o (%s)", r.name()), rd, exp);
  endtask

  task automatic inject(input logic [63:0] p);
    @(posedge clk_i);
    link_v_i <= 1'b1;
    link_data_i <= p;
    @(negedge clk_i);
    while (!link_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    link_v_i <= 1'b0;
    if (p[63]) exp_in_rsp_q.push_back(p);
    else exp_in_req_q.push_back(p);
  endtask

  task automatic wait_sent(input int n_req, input int n_rsp);
    while (sent_req < n_req || sent_rsp < n_rsp) @(negedge clk_i);
  endtask

  // Inbound response, then read it back through the register
  task automatic return_credit();
    rnd_stim = xorshift(rnd_stim);
    inject({1'b1, 3'd0, gx_lp, gy_lp, 20'h0, rnd_stim});
    host_read(e_mc_rsp_entries, 64'h1);
    host_read(e_mc_rsp_fifo, exp_in_rsp_q.pop_front());
  endtask

  task automatic push_req(input logic [31:0] d);
    logic [63:0] p;
    p = {1'b0, 3'd2, 4'hf, 4'hf, d[19:0], d};
    exp_out_req_q.push_back(p);
    host_write(e_bp_req_fifo, p);
  endtask

  task automatic push_rsp(input logic [31:0] d);
    logic [63:0] p;
    p = {1'b1, 3'd1, 4'h3, 4'h4, 20'h0, d};
    exp_out_rsp_q.push_back(p);
    host_write(e_bp_rsp_fifo, p);
  endtask

  initial begin
    reset_i = 1'b1;
    mem_fwd_v_i = 1'b0;
    mem_fwd_we_i = 1'b0;
    mem_fwd_addr_i = '0;
    mem_fwd_data_i = '0;
    mem_rev_ready_and_i = 1'b1;
    link_v_i = 1'b0;
    link_data_i = '0;
    link_ready_i = 1'b1;
    link_hold = 1'b0;
    rand_en = 1'b0;
    rnd_ready = 32'd12322;
    rnd_stim = xorshift(32'd12322);
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (2) @(posedge clk_i);

    host_read(e_endpoint_credits, 64'h0);
    host_read(e_mc_rsp_entries, 64'h0);
    host_read(e_mc_req_entries, 64'h0);
    host_read(e_bp_req_credits, 64'h1);
    host_read(e_bp_rsp_credits, 64'h1);
    begin : unmapped
      logic [63:0] rd;
      @(posedge clk_i);
      mem_fwd_v_i <= 1'b1;
      mem_fwd_we_i <= 1'b0;
      mem_fwd_addr_i <= 20'h0_a000;
      @(negedge clk_i);
      while (!mem_fwd_ready_and_o) @(negedge clk_i);
      @(posedge clk_i);
      mem_fwd_v_i <= 1'b0;
      @(negedge clk_i);
      while (!(mem_rev_v_o && mem_rev_ready_and_i)) @(negedge clk_i);
      rd = mem_rev_data_o;
      compare("mem_rev_data_o", rd, 64'h0);
    end

    for (int i = 1; i <= 3; i++) begin
      push_req(32'h100 + i);
      wait_sent(i, 0);
      host_read(e_endpoint_credits, 64'(i));
    end
    // Fourth request waits for a credit while a response overtakes it
    push_req(32'h104);
    push_rsp(32'hbeef);
    wait_sent(3, 1);
    repeat (20) @(posedge clk_i);
    if (sent_req != 3) begin
      other_errs++;
      $display("Request left the link without a free credit");
    end
    return_credit();
    wait_sent(4, 1);
    for (int i = 0; i < 3; i++) return_credit();
    host_read(e_endpoint_credits, 64'h0);

    inject({1'b0, 3'd3, 4'h1, 4'h2, 20'h0_0040, 32'hcafe_0001});
    inject({1'b0, 3'd3, 4'h1, 4'h2, 20'h0_0044, 32'hcafe_0002});
    for (int i = 0; i < 2; i++) begin
      host_read(e_mc_req_entries, 64'h1);
      host_read(e_mc_req_fifo, exp_in_req_q.pop_front());
    end

    // Full outbound FIFO drops the fifth write
    link_hold <= 1'b1;
    for (int i = 0; i < 4; i++) push_req(32'h200 + i);
    host_read(e_bp_req_credits, 64'h0);
    host_write(e_bp_req_fifo, 64'h0000_0000_dead_dead);
    rand_en <= 1'b1;
    link_hold <= 1'b0;
    for (int i = 1; i <= 4; i++) begin
      wait_sent(4 + i, 1);
      return_credit();
    end

    for (int i = 0; i < 8; i++) begin
      rnd_stim = xorshift(rnd_stim);
      push_req(rnd_stim);
      rnd_stim = xorshift(rnd_stim);
      push_rsp(rnd_stim);
      wait_sent(9 + i, 2 + i);
      return_credit();
      rnd_stim = xorshift(rnd_stim);
      inject({1'b0, 3'd4, 4'h7, 4'h7, 20'h0, rnd_stim});
      host_read(e_mc_req_fifo, exp_in_req_q.pop_front());
    end
    host_read(e_endpoint_credits, 64'h0);
    if (exp_out_req_q.size() != 0 || exp_out_rsp_q.size() != 0) begin
      other_errs++;
      $display("Packets written by the host never left on the link");
    end

    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* manycore_fifo_bridge.f */
source/mc_link_pkg.sv
source/host_reg_pkg.sv
source/link_fifo.sv
source/host_register_decode.sv
source/endpoint_to_fifos.sv
source/manycore_fifo_bridge.sv
tb/manycore_fifo_bridge_properties.sv
tb/manycore_fifo_bridge_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= manycore_fifo_bridge_tb
RTL_TOP   ?= manycore_fifo_bridge
FLIST     ?= manycore_fifo_bridge.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RTL_SRCS  ?= source/mc_link_pkg.sv source/host_reg_pkg.sv source/link_fifo.sv \
             source/host_register_decode.sv source/endpoint_to_fifos.sv \
             source/manycore_fifo_bridge.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
